//--- source/div_sqrt_pkg.sv
/* Shared types and format constants of the binary32 divide and square-root unit.
   Every RTL file refers to these by scoped names. */

package div_sqrt_pkg;

   ////////////////////
   // Format constants
   ////////////////////

   // Fraction field width without hidden bit
   localparam int unsigned C_FRAC_W   = 23;
   localparam int unsigned C_EXP_BIAS = 127;
   // All-ones exponent of inf and NaN
   localparam int unsigned C_EXP_INF  = 255;
   // 24 result bits, guard, round and one spare leading bit
   localparam int unsigned C_ITER_DEF = 27;

   ////////////////////
   // Vector types
   ////////////////////

   // Raw binary32 pattern
   typedef logic [31:0] operand_t;
   // Biased exponent, top bit is the sign after normalization
   typedef logic [8:0] exp_t;
   // Mantissa with hidden bit
   typedef logic [C_FRAC_W:0] mant_t;
   // Rounding mode, codes 4 to 7 behave as nearest-even
   typedef logic [2:0] rm_t;

   // Canonical quiet NaN
   localparam operand_t C_QNAN = 32'h7fc0_0000;

   // Control FSM states
   typedef enum logic [1:0] {
      IDLE,
      LOAD,
      ITER,
      ROUND
   } ctrl_state_t;

endpackage

//--- source/leading_one.sv
/* Priority encoder for the first set bit counted from the MSB.
   The index is the left shift that normalizes a mantissa. */

module leading_one
#(
   parameter int unsigned G_VECTORLEN = 24
)
(
   input  logic [G_VECTORLEN-1:0] Vector_DI,
   output logic [4:0]             First_one_idx_DO,
   output logic                   No_ones_SO
);

   // Set once the first one has been seen
   logic found;

   always_comb
   begin
      found            = 1'b0;
      First_one_idx_DO = '0;
      // Scan from the MSB down, keep the first hit only
      for (int i = 0; i < G_VECTORLEN; i++)
      begin
         if (!found && Vector_DI[G_VECTORLEN-1-i])
         begin
            First_one_idx_DO = 5'(i);
            found            = 1'b1;
         end
      end
   end

   // All-zero vector, index stays 0
   assign No_ones_SO = ~found;

endmodule

//--- source/preprocess.sv
/* Operand decode, classification and subnormal normalization.
   Captures everything on an accepted start and holds it until the next one. */

module preprocess
(
   input  logic                     Clk_CI,
   input  logic                     Rst_RBI,
   input  logic                     Div_start_SI,
   input  logic                     Sqrt_start_SI,
   input  div_sqrt_pkg::operand_t   Operand_a_DI,
   input  div_sqrt_pkg::operand_t   Operand_b_DI,
   input  div_sqrt_pkg::rm_t        RM_SI,
   output div_sqrt_pkg::exp_t       Exp_a_norm_DO,
   output div_sqrt_pkg::exp_t       Exp_b_norm_DO,
   output div_sqrt_pkg::mant_t      Mant_a_norm_DO,
   output div_sqrt_pkg::mant_t      Mant_b_norm_DO,
   output div_sqrt_pkg::rm_t        RM_dly_SO,
   output logic                     Sign_z_DO,
   output logic                     Inf_a_SO,
   output logic                     Inf_b_SO,
   output logic                     Zero_a_SO,
   output logic                     Zero_b_SO,
   output logic                     NaN_a_SO,
   output logic                     NaN_b_SO
);

   logic                                 go;
   logic                                 sign_a, sign_b;
   logic [7:0]                           exp_a, exp_b;
   logic [div_sqrt_pkg::C_FRAC_W-1:0]    frac_a, frac_b;
   logic                                 hb_a, hb_b;
   div_sqrt_pkg::mant_t                  mant_a, mant_b;
   logic [4:0]                           lz_a, lz_b;
   logic                                 no_ones_a, no_ones_b;
   logic                                 exp_max_a, exp_max_b;

   ////////////////////
   // Field split
   ////////////////////

   // Either accepted start loads the operands
   assign go = Div_start_SI | Sqrt_start_SI;

   assign sign_a = Operand_a_DI[31];
   assign sign_b = Operand_b_DI[31];
   assign exp_a  = Operand_a_DI[30:23];
   assign exp_b  = Operand_b_DI[30:23];
   assign frac_a = Operand_a_DI[22:0];
   assign frac_b = Operand_b_DI[22:0];

   // Hidden bit only for a nonzero exponent
   assign hb_a   = |exp_a;
   assign hb_b   = |exp_b;
   assign mant_a = {hb_a, frac_a};
   assign mant_b = {hb_b, frac_b};

   assign exp_max_a = (exp_a == 8'(div_sqrt_pkg::C_EXP_INF));
   assign exp_max_b = (exp_b == 8'(div_sqrt_pkg::C_EXP_INF));

   ////////////////////
   // Leading-one count
   ////////////////////

   leading_one
   #(
      .G_VECTORLEN(div_sqrt_pkg::C_FRAC_W + 1)
   )
   lod_a_i
   (
      .Vector_DI(mant_a),
      .First_one_idx_DO(lz_a),
      .No_ones_SO(no_ones_a)
   );

   leading_one
   #(
      .G_VECTORLEN(div_sqrt_pkg::C_FRAC_W + 1)
   )
   lod_b_i
   (
      .Vector_DI(mant_b),
      .First_one_idx_DO(lz_b),
      .No_ones_SO(no_ones_b)
   );

   ////////////////////
   // Control-side registers
   ////////////////////

   always_ff @(posedge Clk_CI, negedge Rst_RBI)
   begin
      if (~Rst_RBI)
      begin
         Sign_z_DO <= 1'b0;
         RM_dly_SO <= '0;
         Inf_a_SO  <= 1'b0;
         Inf_b_SO  <= 1'b0;
         Zero_a_SO <= 1'b0;
         Zero_b_SO <= 1'b0;
         NaN_a_SO  <= 1'b0;
         NaN_b_SO  <= 1'b0;
      end
      else if (go)
      begin
         // Quotient sign, or sign of the radicand
         Sign_z_DO <= Div_start_SI ? (sign_a ^ sign_b) : sign_a;
         RM_dly_SO <= RM_SI;
         // Class flags
         Inf_a_SO  <= exp_max_a & ~|frac_a;
         Inf_b_SO  <= exp_max_b & ~|frac_b;
         Zero_a_SO <= no_ones_a;
         Zero_b_SO <= no_ones_b;
         NaN_a_SO  <= exp_max_a & |frac_a;
         NaN_b_SO  <= exp_max_b & |frac_b;
      end
   end

   ////////////////////
   // Normalized operands
   ////////////////////

   // Subnormal acts as exponent 1, then drops by the shift
   always_ff @(posedge Clk_CI)
   begin
      if (go)
      begin
         Mant_a_norm_DO <= mant_a << lz_a;
         Mant_b_norm_DO <= mant_b << lz_b;
         Exp_a_norm_DO  <= {1'b0, exp_a} + {8'b0, ~hb_a} - {4'b0, lz_a};
         Exp_b_norm_DO  <= {1'b0, exp_b} + {8'b0, ~hb_b} - {4'b0, lz_b};
      end
   end

endmodule

//--- source/div_sqrt_ctrl.sv
/* Sequencer of the unit: gates the start strobes and walks through load,
   iterate and round, then signals done with one pulse. */

module div_sqrt_ctrl
#(
   parameter int unsigned C_ITER = div_sqrt_pkg::C_ITER_DEF
)
(
   input  logic Clk_CI,
   input  logic Rst_RBI,
   input  logic Div_start_SI,
   input  logic Sqrt_start_SI,
   output logic Div_go_SO,
   output logic Sqrt_go_SO,
   output logic Sqrt_mode_SO,
   output logic Load_SO,
   output logic Iter_en_SO,
   output logic Round_SO,
   output logic Busy_SO,
   output logic Done_SO
);

   localparam int unsigned C_CNT_W = $clog2(C_ITER);

   div_sqrt_pkg::ctrl_state_t state_d, state_q;
   logic [C_CNT_W-1:0]        iter_cnt_q;
   logic                      accept;
   logic                      last_iter;

   ////////////////////
   // Start gating
   ////////////////////

   // Idle and not in the done cycle
   assign accept     = (state_q == div_sqrt_pkg::IDLE) & ~Done_SO;
   // Divide wins over square root
   assign Div_go_SO  = Div_start_SI & accept;
   assign Sqrt_go_SO = Sqrt_start_SI & ~Div_start_SI & accept;

   assign last_iter  = (iter_cnt_q == C_CNT_W'(C_ITER - 1));

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         div_sqrt_pkg::IDLE:  if (Div_go_SO | Sqrt_go_SO) state_d = div_sqrt_pkg::LOAD;
         div_sqrt_pkg::LOAD:  state_d = div_sqrt_pkg::ITER;
         div_sqrt_pkg::ITER:  if (last_iter) state_d = div_sqrt_pkg::ROUND;
         div_sqrt_pkg::ROUND: state_d = div_sqrt_pkg::IDLE;
         default:             state_d = div_sqrt_pkg::IDLE;
      endcase
   end

   ////////////////////
   // State, counter, mode
   ////////////////////

   always_ff @(posedge Clk_CI, negedge Rst_RBI)
   begin
      if (~Rst_RBI)
      begin
         state_q      <= div_sqrt_pkg::IDLE;
         iter_cnt_q   <= '0;
         Sqrt_mode_SO <= 1'b0;
         Done_SO      <= 1'b0;
      end
      else
      begin
         state_q <= state_d;
         // Done follows the round cycle
         Done_SO <= Round_SO;
         if (Div_go_SO | Sqrt_go_SO)
            Sqrt_mode_SO <= Sqrt_go_SO;
         if (Load_SO)
            iter_cnt_q <= '0;
         else if (Iter_en_SO)
            iter_cnt_q <= iter_cnt_q + 1'b1;
      end
   end

   // Strobes to the datapath
   assign Load_SO    = (state_q == div_sqrt_pkg::LOAD);
   assign Iter_en_SO = (state_q == div_sqrt_pkg::ITER);
   assign Round_SO   = (state_q == div_sqrt_pkg::ROUND);
   // Covers the done cycle too
   assign Busy_SO    = (state_q != div_sqrt_pkg::IDLE) | Done_SO;

endmodule

//--- source/iter_unit.sv
/* Radix-2 restoring recurrence for divide and square root.
   One quotient or root bit per enabled cycle, MSB first. */

module iter_unit
#(
   parameter int unsigned C_ITER = div_sqrt_pkg::C_ITER_DEF
)
(
   input  logic                  Clk_CI,
   input  logic                  Rst_RBI,
   input  logic                  Load_SI,
   input  logic                  Iter_en_SI,
   input  logic                  Sqrt_mode_SI,
   input  div_sqrt_pkg::mant_t   Mant_a_DI,
   input  div_sqrt_pkg::mant_t   Mant_b_DI,
   input  logic                  Exp_a_odd_SI,
   output logic [C_ITER-1:0]     Quot_DO,
   output logic                  Rem_nonzero_SO
);

   // Root remainder stays below 2^(C_ITER+1)
   localparam int unsigned C_REM = C_ITER + 2;
   // Radicand holds two bits per root bit
   localparam int unsigned C_RAD = 2 * C_ITER;

   logic [C_REM-1:0] rem_q, rem_d;
   logic [C_REM-1:0] partial, subtrahend, trial_sel;
   logic [C_REM:0]   diff;
   logic             trial_ok;
   logic [C_RAD-1:0] rad_q;
   logic [24:0]      radicand;

   // Odd exponent doubles the radicand
   assign radicand = Exp_a_odd_SI ? {Mant_a_DI, 1'b0} : {1'b0, Mant_a_DI};

   ////////////////////
   // One restoring step
   ////////////////////

   always_comb
   begin
      if (Sqrt_mode_SI)
      begin
         // Bring down the next radicand pair, trial 4q+1
         partial    = {rem_q[C_REM-3:0], rad_q[C_RAD-1 -: 2]};
         subtrahend = {Quot_DO, 2'b01};
      end
      else
      begin
         partial    = rem_q;
         subtrahend = C_REM'(Mant_b_DI);
      end
      diff      = {1'b0, partial} - {1'b0, subtrahend};
      trial_ok  = ~diff[C_REM];
      // Keep the difference or restore
      trial_sel = trial_ok ? diff[C_REM-1:0] : partial;
      // Divide shifts after the step
      rem_d     = Sqrt_mode_SI ? trial_sel : {trial_sel[C_REM-2:0], 1'b0};
   end

   ////////////////////
   // Remainder and result
   ////////////////////

   always_ff @(posedge Clk_CI, negedge Rst_RBI)
   begin
      if (~Rst_RBI)
      begin
         rem_q   <= '0;
         Quot_DO <= '0;
      end
      else if (Load_SI)
      begin
         rem_q   <= Sqrt_mode_SI ? '0 : C_REM'(Mant_a_DI);
         Quot_DO <= '0;
      end
      else if (Iter_en_SI)
      begin
         rem_q   <= rem_d;
         Quot_DO <= {Quot_DO[C_ITER-2:0], trial_ok};
      end
   end

   // Radicand left-aligned, consumed two bits per step
   always_ff @(posedge Clk_CI)
   begin
      if (Load_SI)
         rad_q <= {radicand, {(C_RAD-25){1'b0}}};
      else if (Iter_en_SI)
         rad_q <= {rad_q[C_RAD-3:0], 2'b00};
   end

   // Sticky source
   assign Rem_nonzero_SO = |rem_q;

endmodule

//--- source/norm_round.sv
/* Result exponent, normalization, rounding and special-case rules.
   The packed binary32 result is registered on the round strobe. */

module norm_round
#(
   parameter int unsigned C_ITER = div_sqrt_pkg::C_ITER_DEF
)
(
   input  logic                     Clk_CI,
   input  logic                     Rst_RBI,
   input  logic                     Round_SI,
   input  logic                     Sqrt_mode_SI,
   input  div_sqrt_pkg::exp_t       Exp_a_DI,
   input  div_sqrt_pkg::exp_t       Exp_b_DI,
   input  logic [C_ITER-1:0]        Quot_DI,
   input  logic                     Rem_nonzero_SI,
   input  logic                     Sign_z_DI,
   input  div_sqrt_pkg::rm_t        RM_SI,
   input  logic                     Inf_a_SI,
   input  logic                     Inf_b_SI,
   input  logic                     Zero_a_SI,
   input  logic                     Zero_b_SI,
   input  logic                     NaN_a_SI,
   input  logic                     NaN_b_SI,
   output div_sqrt_pkg::operand_t   Result_DO
);

   localparam logic [10:0] C_BIAS = 11'(div_sqrt_pkg::C_EXP_BIAS);

   logic [10:0]       exp_a_x, exp_b_x, exp_unb_a, exp_pre, exp_fin;
   logic [C_ITER-1:0] quot_norm;
   logic [23:0]       mant_trunc;
   logic [24:0]       mant_rnd;
   logic              guard, round_bit, sticky, inexact, round_up;
   logic              res_nan, res_inf, res_zero, ovf, unf;
   div_sqrt_pkg::operand_t result_d;

   ////////////////////
   // Exponent
   ////////////////////

   // Sign-extend to keep headroom for the difference
   assign exp_a_x   = {{2{Exp_a_DI[8]}}, Exp_a_DI};
   assign exp_b_x   = {{2{Exp_b_DI[8]}}, Exp_b_DI};
   assign exp_unb_a = exp_a_x - C_BIAS;

   // Floor of half the unbiased exponent for the root
   assign exp_pre = (Sqrt_mode_SI ? ({exp_unb_a[10], exp_unb_a[10:1]} + C_BIAS)
                                  : (exp_a_x - exp_b_x + C_BIAS))
                    - {10'b0, ~Quot_DI[C_ITER-1]};

   // Clear spare leading bit means a shift by one
   assign quot_norm  = Quot_DI[C_ITER-1] ? Quot_DI : {Quot_DI[C_ITER-2:0], 1'b0};
   assign mant_trunc = quot_norm[C_ITER-1 -: 24];
   assign guard      = quot_norm[C_ITER-25];
   assign round_bit  = quot_norm[C_ITER-26];
   assign sticky     = |quot_norm[C_ITER-27:0] | Rem_nonzero_SI;
   assign inexact    = guard | round_bit | sticky;

   ////////////////////
   // Rounding
   ////////////////////

   always_comb
   begin
      case (RM_SI)
         3'd1:    round_up = 1'b0;
         3'd2:    round_up = Sign_z_DI & inexact;
         3'd3:    round_up = ~Sign_z_DI & inexact;
         default: round_up = guard & (round_bit | sticky | mant_trunc[0]);
      endcase
   end

   // Carry out bumps the exponent and leaves a zero fraction
   assign mant_rnd = {1'b0, mant_trunc} + 25'(round_up);
   assign exp_fin  = exp_pre + 11'(mant_rnd[24]);

   assign ovf = ~exp_fin[10] & (exp_fin[9:0] >= 10'(div_sqrt_pkg::C_EXP_INF));
   // Subnormal range flushes
   assign unf = exp_fin[10] | (exp_fin == '0);

   ////////////////////
   // Specials
   ////////////////////

   assign res_nan  = Sqrt_mode_SI ? (NaN_a_SI | (Sign_z_DI & ~Zero_a_SI))
                                  : (NaN_a_SI | NaN_b_SI | (Zero_a_SI & Zero_b_SI)
                                     | (Inf_a_SI & Inf_b_SI));
   assign res_inf  = Sqrt_mode_SI ? Inf_a_SI : (Inf_a_SI | Zero_b_SI);
   assign res_zero = Sqrt_mode_SI ? Zero_a_SI : (Zero_a_SI | Inf_b_SI);

   always_comb
   begin
      if (res_nan)
         result_d = div_sqrt_pkg::C_QNAN;
      else if (res_inf | (~res_zero & ovf))
         result_d = {Sign_z_DI, 8'hff, 23'b0};
      else if (res_zero | unf)
         result_d = {Sign_z_DI, 31'b0};
      else
         result_d = {Sign_z_DI, exp_fin[7:0], mant_rnd[22:0]};
   end

   always_ff @(posedge Clk_CI, negedge Rst_RBI)
   begin
      if (~Rst_RBI)
         Result_DO <= '0;
      else if (Round_SI)
         Result_DO <= result_d;
   end

endmodule

//--- source/div_sqrt_top.sv
/* Top level of the binary32 divide and square-root unit.
   Connects the control FSM with decode, recurrence and rounding. */

module div_sqrt_top
#(
   parameter int unsigned C_ITER = div_sqrt_pkg::C_ITER_DEF
)
(
   input  logic                     Clk_CI,
   input  logic                     Rst_RBI,
   input  logic                     Div_start_SI,
   input  logic                     Sqrt_start_SI,
   input  div_sqrt_pkg::operand_t   Operand_a_DI,
   input  div_sqrt_pkg::operand_t   Operand_b_DI,
   input  div_sqrt_pkg::rm_t        RM_SI,
   output div_sqrt_pkg::operand_t   Result_DO,
   output logic                     Busy_SO,
   output logic                     Done_SO
);

   logic Div_go_S, Sqrt_go_S, Sqrt_mode_S, Load_S, Iter_en_S, Round_S;
   div_sqrt_pkg::exp_t  exp_a_norm, exp_b_norm;
   div_sqrt_pkg::mant_t mant_a_norm, mant_b_norm;
   div_sqrt_pkg::rm_t   rm_dly;
   logic                sign_z, inf_a, inf_b, zero_a, zero_b, nan_a, nan_b;
   logic                exp_a_odd, rem_nonzero;
   logic [C_ITER-1:0]   quot;

   div_sqrt_ctrl #(.C_ITER(C_ITER)) ctrl_i
   (
      .Clk_CI, .Rst_RBI, .Div_start_SI, .Sqrt_start_SI,
      .Div_go_SO(Div_go_S), .Sqrt_go_SO(Sqrt_go_S), .Sqrt_mode_SO(Sqrt_mode_S),
      .Load_SO(Load_S), .Iter_en_SO(Iter_en_S), .Round_SO(Round_S), .Busy_SO, .Done_SO
   );

   preprocess prep_i
   (
      .Clk_CI, .Rst_RBI, .Div_start_SI(Div_go_S), .Sqrt_start_SI(Sqrt_go_S),
      .Operand_a_DI, .Operand_b_DI, .RM_SI,
      .Exp_a_norm_DO(exp_a_norm), .Exp_b_norm_DO(exp_b_norm),
      .Mant_a_norm_DO(mant_a_norm), .Mant_b_norm_DO(mant_b_norm), .RM_dly_SO(rm_dly),
      .Sign_z_DO(sign_z), .Inf_a_SO(inf_a), .Inf_b_SO(inf_b), .Zero_a_SO(zero_a),
      .Zero_b_SO(zero_b), .NaN_a_SO(nan_a), .NaN_b_SO(nan_b)
   );

   // Bias is odd, so an even biased exponent is an odd unbiased one
   assign exp_a_odd = ~exp_a_norm[0];

   iter_unit #(.C_ITER(C_ITER)) iter_i
   (
      .Clk_CI, .Rst_RBI, .Load_SI(Load_S), .Iter_en_SI(Iter_en_S),
      .Sqrt_mode_SI(Sqrt_mode_S), .Mant_a_DI(mant_a_norm), .Mant_b_DI(mant_b_norm),
      .Exp_a_odd_SI(exp_a_odd), .Quot_DO(quot), .Rem_nonzero_SO(rem_nonzero)
   );

   norm_round #(.C_ITER(C_ITER)) round_i
   (
      .Clk_CI, .Rst_RBI, .Round_SI(Round_S), .Sqrt_mode_SI(Sqrt_mode_S),
      .Exp_a_DI(exp_a_norm), .Exp_b_DI(exp_b_norm), .Quot_DI(quot),
      .Rem_nonzero_SI(rem_nonzero), .Sign_z_DI(sign_z), .RM_SI(rm_dly),
      .Inf_a_SI(inf_a), .Inf_b_SI(inf_b), .Zero_a_SI(zero_a), .Zero_b_SI(zero_b),
      .NaN_a_SI(nan_a), .NaN_b_SI(nan_b), .Result_DO
   );

endmodule

//--- dv/tb_clk_gen.sv
/* Testbench clock and reset source for the divide and square-root unit.
   8 ns clock, active-low reset held for the first four cycles. */

module tb_clk_gen
(
   output logic Clk_CI,
   output logic Rst_RBI
);

   timeunit 1ns;
   timeprecision 1ps;

   // Free-running clock
   initial
   begin
      Clk_CI = 1'b0;
      forever
         #4 Clk_CI = ~Clk_CI;
   end

   // Reset low for four rising edges
   initial
   begin
      Rst_RBI = 1'b0;
      repeat (4) @(posedge Clk_CI);
      Rst_RBI <= 1'b1;
   end

endmodule

//--- dv/tb_div_sqrt.sv
/* Directed testbench of the binary32 divide and square-root unit.
   Compares every result against an integer model of the IEEE rules. */

module tb_div_sqrt;

   timeunit 1ns;
   timeprecision 1ps;

   logic        Clk_CI;
   logic        Rst_RBI;
   logic        div_start;
   logic        sqrt_start;
   logic [31:0] operand_a;
   logic [31:0] operand_b;
   logic [2:0]  rm;
   logic [31:0] result;
   logic        busy;
   logic        done;
   logic [31:0] lfsr_q;

   tb_clk_gen clk_gen_i
   (
      .Clk_CI(Clk_CI),
      .Rst_RBI(Rst_RBI)
   );

   div_sqrt_top dut_i
   (
      .Clk_CI(Clk_CI),
      .Rst_RBI(Rst_RBI),
      .Div_start_SI(div_start),
      .Sqrt_start_SI(sqrt_start),
      .Operand_a_DI(operand_a),
      .Operand_b_DI(operand_b),
      .RM_SI(rm),
      .Result_DO(result),
      .Busy_SO(busy),
      .Done_SO(done)
   );

   ////////////////////
   // Reference model
   ////////////////////

   // Normalized exponent and 24-bit mantissa of one operand
   // Subnormals start at exponent 1
   function automatic void decode_operand(input logic [31:0] op, output int e,
                                          output longint unsigned m);
      e = int'(op[30:23]);
      m = {40'd0, (op[30:23] != 8'd0), op[22:0]};
      if (e == 0)
      begin
         e = 1;
         while (m != 0 && m[23] == 1'b0)
         begin
            m = m << 1;
            e = e - 1;
         end
      end
   endfunction

   // Model of finite operands only
   function automatic logic [31:0] ref_result(input logic sq, input logic [31:0] a,
                                              input logic [31:0] b, input logic [2:0] mode);
      int              ea;
      int              eb;
      int              ez;
      longint unsigned ma;
      longint unsigned mb;
      longint unsigned num;
      longint unsigned q;
      longint unsigned rem;
      longint unsigned trial;
      longint unsigned mant;
      logic            sz;
      logic            g;
      logic            r;
      logic            st;
      logic            up;
      decode_operand(a, ea, ma);
      decode_operand(b, eb, mb);
      if (sq)
      begin
         sz  = a[31];
         // Floor of half the unbiased exponent
         ez  = ((ea - 127) >>> 1) + 127;
         num = ((((ea - 127) % 2) != 0) ? (ma << 1) : ma) << 29;
         q   = 0;
         // Largest root whose square fits
         for (int i = 26; i >= 0; i--)
         begin
            trial = q | (64'd1 << i);
            if (trial * trial <= num)
               q = trial;
         end
         rem = num - q * q;
      end
      else
      begin
         sz  = a[31] ^ b[31];
         ez  = ea - eb + 127;
         num = ma << 26;
         q   = num / mb;
         rem = num % mb;
      end
      // Quotient below one
      if (q[26] == 1'b0)
      begin
         q  = q << 1;
         ez = ez - 1;
      end
      g    = q[2];
      r    = q[1];
      st   = q[0] | (rem != 0);
      mant = q >> 3;
      case (mode)
         3'd1:    up = 1'b0;
         3'd2:    up = sz & (g | r | st);
         3'd3:    up = ~sz & (g | r | st);
         default: up = g & (r | st | mant[0]);
      endcase
      mant = mant + 64'(up);
      if (mant[24])
      begin
         mant = mant >> 1;
         ez   = ez + 1;
      end
      if (ez >= 255)
         return {sz, 8'hff, 23'd0};
      if (ez <= 0)
         return {sz, 31'd0};
      return {sz, 8'(ez), mant[22:0]};
   endfunction

   ////////////////////
   // Random source
   ////////////////////

   // Right-shifting Galois form with taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   task automatic rand_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr_q = lfsr_next(lfsr_q);
         v      = {v[30:0], lfsr_q[0]};
      end
   endtask

   // Normal operand with exponent in 64 to 190
   task automatic rand_operand(output logic [31:0] op);
      logic [31:0] s;
      logic [31:0] e;
      logic [31:0] f;
      rand_bits(1, s);
      rand_bits(8, e);
      rand_bits(23, f);
      op = {s[0], 8'(64 + e % 127), f[22:0]};
   endtask

   ////////////////////
   // Checking and driving
   ////////////////////

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Test failed");
      $fatal(1);
   endtask

   task automatic check_val(input string name, input logic [31:0] expv,
                            input logic [31:0] actv);
      if (actv !== expv)
         abort_run($sformatf("ERR %s expected %08h actual %08h", name, expv, actv));
   endtask

   // One-cycle start strobe
   task automatic start_op(input logic div_s, input logic sqrt_s, input logic [31:0] a,
                           input logic [31:0] b, input logic [2:0] mode);
      @(posedge Clk_CI);
      div_start  <= div_s;
      sqrt_start <= sqrt_s;
      operand_a  <= a;
      operand_b  <= b;
      rm         <= mode;
      @(posedge Clk_CI);
      div_start  <= 1'b0;
      sqrt_start <= 1'b0;
   endtask

   // Counts cycles from the edge that samples the start
   task automatic wait_done(input string name, output logic [31:0] res, output int cyc);
      cyc = 1;
      @(negedge Clk_CI);
      while (done !== 1'b1 && cyc < 100)
      begin
         @(negedge Clk_CI);
         cyc++;
      end
      if (done !== 1'b1)
         abort_run($sformatf("%s: Done_SO did not arrive within %0d cycles", name, cyc));
      res = result;
   endtask

   task automatic run_op(input string name, input logic sq, input logic [31:0] a,
                         input logic [31:0] b, input logic [2:0] mode,
                         output logic [31:0] res, output int cyc);
      start_op(~sq, sq, a, b, mode);
      wait_done(name, res, cyc);
   endtask

   task automatic expect_op(input string name, input logic sq, input logic [31:0] a,
                            input logic [31:0] b, input logic [2:0] mode,
                            input logic [31:0] expv);
      logic [31:0] res;
      int          cyc;
      run_op(name, sq, a, b, mode, res, cyc);
      check_val(name, expv, res);
      check_val({name, " latency"}, 32'd30, cyc);
   endtask

   ////////////////////
   // Directed tests
   ////////////////////

   task automatic exact_results();
      for (int m = 0; m < 4; m++)
      begin
         expect_op($sformatf("6/3 rm%0d", m), 1'b0, 32'h40c0_0000, 32'h4040_0000, 3'(m),
                   32'h4000_0000);
         expect_op($sformatf("1/4 rm%0d", m), 1'b0, 32'h3f80_0000, 32'h4080_0000, 3'(m),
                   32'h3e80_0000);
         expect_op($sformatf("sqrt 16 rm%0d", m), 1'b1, 32'h4180_0000, 32'h0, 3'(m),
                   32'h4080_0000);
         expect_op($sformatf("sqrt 2.25 rm%0d", m), 1'b1, 32'h4010_0000, 32'h0, 3'(m),
                   32'h3fc0_0000);
      end
   endtask

   // Positive inexact result in all four modes
   task automatic round_set(input string name, input logic sq, input logic [31:0] a,
                            input logic [31:0] b, input logic [31:0] rne_val);
      logic [31:0] r [4];
      logic [31:0] res;
      int          cyc;
      for (int m = 0; m < 4; m++)
      begin
         run_op(name, sq, a, b, 3'(m), res, cyc);
         r[m] = res;
         check_val($sformatf("%s rm%0d", name, m), ref_result(sq, a, b, 3'(m)), res);
      end
      // Truncation and round-down agree above zero
      check_val({name, " rz vs rdn"}, r[1], r[2]);
      check_val({name, " rup one ulp"}, r[1] + 32'd1, r[3]);
      check_val({name, " rne"}, rne_val, r[0]);
   endtask

   task automatic rounding_modes();
      round_set("1/3", 1'b0, 32'h3f80_0000, 32'h4040_0000, 32'h3eaa_aaab);
      round_set("2/3", 1'b0, 32'h4000_0000, 32'h4040_0000, 32'h3f2a_aaab);
      round_set("sqrt 2", 1'b1, 32'h4000_0000, 32'h0, 32'h3fb5_04f3);
      // Directions swap for a negative result
      expect_op("-1/3 rdn", 1'b0, 32'hbf80_0000, 32'h4040_0000, 3'd2, 32'hbeaa_aaab);
      expect_op("-1/3 rup", 1'b0, 32'hbf80_0000, 32'h4040_0000, 3'd3, 32'hbeaa_aaaa);
   endtask

   task automatic special_operands();
      // Canonical NaN cases
      expect_op("nan/1", 1'b0, 32'h7fc0_0000, 32'h3f80_0000, 3'd0, 32'h7fc0_0000);
      expect_op("1/snan", 1'b0, 32'h3f80_0000, 32'h7f80_0001, 3'd0, 32'h7fc0_0000);
      expect_op("0/0", 1'b0, 32'h0, 32'h0, 3'd0, 32'h7fc0_0000);
      expect_op("inf/-inf", 1'b0, 32'h7f80_0000, 32'hff80_0000, 3'd0, 32'h7fc0_0000);
      expect_op("sqrt -4", 1'b1, 32'hc080_0000, 32'h0, 3'd0, 32'h7fc0_0000);
      expect_op("sqrt nan", 1'b1, 32'h7fc0_0000, 32'h0, 3'd0, 32'h7fc0_0000);
      // Signed infinities
      expect_op("1/0", 1'b0, 32'h3f80_0000, 32'h0, 3'd0, 32'h7f80_0000);
      expect_op("-1/0", 1'b0, 32'hbf80_0000, 32'h0, 3'd0, 32'hff80_0000);
      expect_op("1/-0", 1'b0, 32'h3f80_0000, 32'h8000_0000, 3'd0, 32'hff80_0000);
      expect_op("inf/2", 1'b0, 32'h7f80_0000, 32'h4000_0000, 3'd0, 32'h7f80_0000);
      expect_op("-inf/2", 1'b0, 32'hff80_0000, 32'h4000_0000, 3'd0, 32'hff80_0000);
      // Signed zeros
      expect_op("0/3", 1'b0, 32'h0, 32'h4040_0000, 3'd0, 32'h0);
      expect_op("-0/3", 1'b0, 32'h8000_0000, 32'h4040_0000, 3'd0, 32'h8000_0000);
      expect_op("3/inf", 1'b0, 32'h4040_0000, 32'h7f80_0000, 3'd0, 32'h0);
      expect_op("3/-inf", 1'b0, 32'h4040_0000, 32'hff80_0000, 3'd0, 32'h8000_0000);
      expect_op("sqrt -0", 1'b1, 32'h8000_0000, 32'h0, 3'd0, 32'h8000_0000);
      expect_op("sqrt inf", 1'b1, 32'h7f80_0000, 32'h0, 3'd0, 32'h7f80_0000);
   endtask

   task automatic subnormal_and_range();
      // 2^-127 over 2^-10
      expect_op("subn/2^-10", 1'b0, 32'h0040_0000, 32'h3a80_0000, 3'd0, 32'h0500_0000);
      expect_op("subn2/2^-10", 1'b0, 32'h000a_bcde, 32'h3a80_0000, 3'd0,
                ref_result(1'b0, 32'h000a_bcde, 32'h3a80_0000, 3'd0));
      expect_op("sqrt subn", 1'b1, 32'h0000_1234, 32'h0, 3'd3,
                ref_result(1'b1, 32'h0000_1234, 32'h0, 3'd3));
      // Overflow ignores the mode
      expect_op("huge/tiny", 1'b0, 32'h7f00_0000, 32'h0080_0000, 3'd0, 32'h7f80_0000);
      expect_op("huge/tiny rz", 1'b0, 32'h7f00_0000, 32'h0080_0000, 3'd1, 32'h7f80_0000);
      expect_op("tiny/huge", 1'b0, 32'h0080_0000, 32'h7f00_0000, 3'd0, 32'h0);
      expect_op("-tiny/huge", 1'b0, 32'h8080_0000, 32'h7f00_0000, 3'd0, 32'h8000_0000);
   endtask

   task automatic random_regression();
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] m;
      logic        sq;
      for (int i = 0; i < 200; i++)
      begin
         rand_operand(a);
         rand_operand(b);
         rand_bits(2, m);
         // Odd runs take the root of a positive operand
         sq = i[0];
         if (sq)
            a[31] = 1'b0;
         expect_op($sformatf("random %0d", i), sq, a, b, m[2:0],
                   ref_result(sq, a, b, m[2:0]));
      end
   endtask

   task automatic control_behavior();
      logic [31:0] res;
      int          cyc;
      // Second start lands while the divide runs
      start_op(1'b1, 1'b0, 32'h40c0_0000, 32'h4040_0000, 3'd0);
      @(negedge Clk_CI);
      check_val("busy during op", 32'd1, 32'(busy));
      start_op(1'b0, 1'b1, 32'h4180_0000, 32'h0, 3'd0);
      wait_done("start while busy", res, cyc);
      check_val("start while busy", 32'h4000_0000, res);
      for (int i = 0; i < 40; i++)
      begin
         @(negedge Clk_CI);
         if (done)
            abort_run("Done_SO pulsed again after a start that should have been dropped");
      end
      check_val("held result", 32'h4000_0000, result);
      check_val("idle busy", 32'd0, 32'(busy));
      // Divide has priority
      start_op(1'b1, 1'b1, 32'h40c0_0000, 32'h4040_0000, 3'd0);
      wait_done("both strobes", res, cyc);
      check_val("both strobes", 32'h4000_0000, res);
   endtask

   task automatic wait_reset();
      int n;
      n = 0;
      while (Rst_RBI !== 1'b1 && n < 20)
      begin
         @(posedge Clk_CI);
         n++;
      end
      if (Rst_RBI !== 1'b1)
         abort_run("reset was never released");
      @(negedge Clk_CI);
   endtask

   ////////////////////
   // Sequence
   ////////////////////

   initial
   begin
      div_start  = 1'b0;
      sqrt_start = 1'b0;
      operand_a  = '0;
      operand_b  = '0;
      rm         = '0;
      lfsr_q     = 32'h5feb_a580;
      wait_reset();
      check_val("reset busy", 32'd0, 32'(busy));
      check_val("reset done", 32'd0, 32'(done));
      check_val("reset result", 32'd0, result);
      exact_results();
      rounding_modes();
      special_operands();
      subnormal_and_range();
      random_regression();
      control_behavior();
      $display("Test passed");
      $finish;
   end

endmodule

//--- filelist.f
source/div_sqrt_pkg.sv
source/leading_one.sv
source/preprocess.sv
source/div_sqrt_ctrl.sv
source/iter_unit.sv
source/norm_round.sv
source/div_sqrt_top.sv
dv/tb_clk_gen.sv
dv/tb_div_sqrt.sv

//--- run.sh
#!/bin/sh
# Build and run the divide and square-root testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf build
verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
   --top-module tb_div_sqrt -f filelist.f --Mdir build -o sim_div_sqrt

./build/sim_div_sqrt 2>&1 | tee build/sim.log

if grep -q "Test failed" build/sim.log; then
   echo "Simulation failed"
   exit 1
fi
if ! grep -q "Test passed" build/sim.log; then
   echo "Simulation ended without a result"
   exit 1
fi
echo "Simulation passed"
